// ==== driveVectors.txt ====
// enable pause inductance ir1k ir10k disable wait | high cycles A.inA A.inB B.inA B.inB | done
// All hex. done F means drive only, no measurement after the wait
0 0 0 0 0 0 14  0 0 0 0  0
1 0 0 0 0 0 28  4 0 0 4  0
1 0 0 1 0 0 1E  8 0 0 8  0
1 0 0 0 0 0 64  0 0 0 0  1
0 0 0 0 0 0 14  0 0 0 0  1
1 0 0 0 0 0 28  4 0 0 4  0
1 0 0 0 1 0 1E  0 4 4 0  0
1 0 0 0 0 0 64  0 0 0 0  1
0 0 0 0 0 0 14  0 0 0 0  1
1 0 0 0 0 0 28  4 0 0 4  0
1 1 0 0 0 0 28  0 0 0 0  0
1 0 0 0 0 0 28  4 0 0 4  0
1 0 1 0 0 0 28  0 C 0 C  0
1 0 0 0 0 0 C8  4 0 0 4  0
1 0 0 0 0 1 0A  0 0 0 0  0
1 0 0 0 0 0 28  4 0 0 4  0
1 0 0 1 0 0 01  F F F F  F
1 0 0 0 0 0 28  4 0 0 4  0

// ==== build.f ====
robotDrivePkg.sv
sensorConditioner.sv
goalDirectionControl.sv
pwmChannel.sv
bridgeDriver.sv
robotDriveTop.sv
tbClock.sv
tbRobotDrive.sv

// ==== runSim.sh ====
#!/bin/sh
# Build and run the robot drive testbench with Verilator, fail if the log reports errors
set -e

verilator --binary --timing -Wno-fatal -f build.f --top-module tbRobotDrive -o simRobotDrive

./obj_dir/simRobotDrive > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
    exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
    echo "Simulation ended without a final result line"
    exit 1
fi
exit 0

// ==== tbRobotDrive.sv ====
// Vector-driven testbench of the robot drive that counts bridge pin high cycles and checks done
`timescale 1ns/10ps
`default_nettype none

module tbRobotDrive;

    // ============================================================
    // Vector layout
    // ============================================================
    localparam int NUM_FIELDS = 12;
    localparam int MAX_STEPS  = 32;
    localparam int F_WAIT     = 6;
    localparam int F_DONE     = 11;
    // Marks an unused memory word and a drive-only step
    localparam logic [15:0] EMPTY = 16'hFFFF;
    localparam logic [15:0] SKIP  = 16'h000F;

    logic clk;
    logic arstN;
    logic enable;
    logic pause;
    logic inductance;
    logic ir1k;
    logic ir10k;
    logic motorDisable;
    robotDrivePkg::bridgePinsT [robotDrivePkg::NUM_MOTORS-1:0] motorPins;
    logic done;

    logic [15:0] vecMem [0:NUM_FIELDS*MAX_STEPS-1];
    int numSteps;
    int errorCount;
    int cycleCount = 0;
    int cycleLimit;

    tbClock i_tbClock (
        .clk   (clk),
        .arstN (arstN)
    );

    robotDriveTop i_robotDriveTop (
        .clk          (clk),
        .arstN        (arstN),
        .enable       (enable),
        .pause        (pause),
        .inductance   (inductance),
        .ir1k         (ir1k),
        .ir10k        (ir10k),
        .motorDisable (motorDisable),
        .motorPins    (motorPins),
        .done         (done)
    );

    task automatic compareValue(input string what, input int got, input int exp);
        if (got != exp) begin
            errorCount++;
            $display("[ERROR] %0d ns: %s expected %0d, got %0d", $time, what, exp, got);
        end
    endtask

    // Drive one step, wait, then count pin high cycles over one PWM period
    task automatic runStep(input int s);
        int base;
        int hiAA;
        int hiAB;
        int hiBA;
        int hiBB;
        base = s * NUM_FIELDS;
        hiAA = 0;
        hiAB = 0;
        hiBA = 0;
        hiBB = 0;
        @(posedge clk);
        #2;
        enable       = vecMem[base][0];
        pause        = vecMem[base+1][0];
        inductance   = vecMem[base+2][0];
        ir1k         = vecMem[base+3][0];
        ir10k        = vecMem[base+4][0];
        motorDisable = vecMem[base+5][0];
        repeat (int'(vecMem[base+F_WAIT])) @(posedge clk);
        if (vecMem[base+F_DONE] != SKIP) begin
            repeat (robotDrivePkg::PWM_PERIOD) begin
                @(negedge clk);
                hiAA += int'(motorPins[robotDrivePkg::MOTOR_A].inA);
                hiAB += int'(motorPins[robotDrivePkg::MOTOR_A].inB);
                hiBA += int'(motorPins[robotDrivePkg::MOTOR_B].inA);
                hiBB += int'(motorPins[robotDrivePkg::MOTOR_B].inB);
            end
            compareValue($sformatf("step %0d motor A inA", s), hiAA, int'(vecMem[base+7]));
            compareValue($sformatf("step %0d motor A inB", s), hiAB, int'(vecMem[base+8]));
            compareValue($sformatf("step %0d motor B inA", s), hiBA, int'(vecMem[base+9]));
            compareValue($sformatf("step %0d motor B inB", s), hiBB, int'(vecMem[base+10]));
            compareValue($sformatf("step %0d done", s), int'(done), int'(vecMem[base+F_DONE]));
        end
    endtask

    // ============================================================
    // Cycle limit
    // ============================================================
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
            $display("Timeout: simulation ran past %0d cycles without finishing", cycleLimit);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        enable       = 1'b0;
        pause        = 1'b0;
        inductance   = 1'b0;
        ir1k         = 1'b0;
        ir10k        = 1'b0;
        motorDisable = 1'b0;
        errorCount   = 0;
        cycleLimit   = 0;
        numSteps     = 0;
        for (int i = 0; i < NUM_FIELDS * MAX_STEPS; i++) begin
            vecMem[i] = EMPTY;
        end
        $readmemh("driveVectors.txt", vecMem);

        // Sum of waits plus one measure window per step and a fixed margin
        while (numSteps < MAX_STEPS && vecMem[numSteps*NUM_FIELDS] != EMPTY) begin
            cycleLimit += int'(vecMem[numSteps*NUM_FIELDS+F_WAIT]);
            cycleLimit += robotDrivePkg::PWM_PERIOD;
            numSteps++;
        end
        cycleLimit += 200;
        if (numSteps == 0) begin
            errorCount++;
            $display("No test steps could be read from driveVectors.txt");
        end

        @(posedge arstN);
        for (int s = 0; s < numSteps; s++) begin
            runStep(s);
        end

        $display("Steps run: %0d, errors: %0d", numSteps, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tbClock.sv ====
// Testbench clock and reset source, 20 ns clock with reset held low for the first five cycles
`timescale 1ns/10ps
`default_nettype none

module tbClock (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // Release away from the clock edge
    initial begin
        arstN = 1'b0;
        repeat (5) @(posedge clk);
        #2 arstN = 1'b1;
    end

endmodule

`default_nettype wire

// ==== robotDriveTop.sv ====
// Top level of the robot drive, connects conditioner, search FSM, PWM channels and bridge driver
`timescale 1ns/10ps
`default_nettype none

module robotDriveTop (
    input  wire   clk,
    input  wire   arstN,
    input  wire   enable,
    input  wire   pause,
    input  wire   inductance,
    input  wire   ir1k,
    input  wire   ir10k,
    input  wire   motorDisable,
    output robotDrivePkg::bridgePinsT [robotDrivePkg::NUM_MOTORS-1:0] motorPins,
    output logic  done
);

    robotDrivePkg::sensorBusT sensors;
    robotDrivePkg::motorCmdT [robotDrivePkg::NUM_MOTORS-1:0] motorCmd;
    logic [robotDrivePkg::NUM_MOTORS-1:0] pwmOn;

    // ============================================================
    // Input conditioning and search control
    // ============================================================
    sensorConditioner i_sensorConditioner (
        .clk        (clk),
        .arstN      (arstN),
        .enable     (enable),
        .pause      (pause),
        .inductance (inductance),
        .ir1k       (ir1k),
        .ir10k      (ir10k),
        .sensors    (sensors)
    );

    goalDirectionControl i_goalDirectionControl (
        .clk      (clk),
        .arstN    (arstN),
        .sensors  (sensors),
        .motorCmd (motorCmd),
        .done     (done)
    );

    // ============================================================
    // Motor outputs
    // ============================================================
    // Entry 0 drives motor A and entry 1 drives motor B
    for (genvar m = 0; m < robotDrivePkg::NUM_MOTORS; m++) begin : gPwm
        pwmChannel i_pwmChannel (
            .clk     (clk),
            .arstN   (arstN),
            .dutySel (motorCmd[m].dutySel),
            .pwmOn   (pwmOn[m])
        );
    end

    bridgeDriver i_bridgeDriver (
        .clk          (clk),
        .arstN        (arstN),
        .motorCmd     (motorCmd),
        .pwmOn        (pwmOn),
        .motorDisable (motorDisable),
        .motorPins    (motorPins)
    );

endmodule

`default_nettype wire

// ==== bridgeDriver.sv ====
// H-bridge pin driver, maps direction and PWM to bridge inputs with reversal dead time and disable
`timescale 1ns/10ps
`default_nettype none

module bridgeDriver (
    input  wire                       clk,
    input  wire                       arstN,
    input  wire robotDrivePkg::motorCmdT [robotDrivePkg::NUM_MOTORS-1:0] motorCmd,
    input  wire  [robotDrivePkg::NUM_MOTORS-1:0] pwmOn,
    input  wire                       motorDisable,
    output robotDrivePkg::bridgePinsT [robotDrivePkg::NUM_MOTORS-1:0] motorPins
);

    // ============================================================
    // One bridge per motor
    // ============================================================
    for (genvar m = 0; m < robotDrivePkg::NUM_MOTORS; m++) begin : gBridge

        robotDrivePkg::motorDirT cmdDir;
        // Last direction actually driven, off once a dead interval has started
        robotDrivePkg::motorDirT lastDir;
        logic [robotDrivePkg::DEAD_CNT_W-1:0] deadCnt;
        logic reversal;
        robotDrivePkg::bridgePinsT pinsNext;
        robotDrivePkg::bridgePinsT pinsQ;

        assign cmdDir   = motorCmd[m].dir;
        assign reversal =
            (cmdDir == robotDrivePkg::forward  && lastDir == robotDrivePkg::backward) ||
            (cmdDir == robotDrivePkg::backward && lastDir == robotDrivePkg::forward);

        always_comb begin
            pinsNext = '0;
            if (!motorDisable && deadCnt == '0 && !reversal) begin
                case (cmdDir)
                    robotDrivePkg::forward:  pinsNext.inA = pwmOn[m];
                    robotDrivePkg::backward: pinsNext.inB = pwmOn[m];
                    default: begin
                        // Motor off keeps both inputs low
                    end
                endcase
            end
        end

        always_ff @(posedge clk or negedge arstN) begin
            if (!arstN) begin
                lastDir <= robotDrivePkg::off;
                deadCnt <= '0;
                pinsQ   <= '0;
            end else begin
                pinsQ <= pinsNext;
                if (deadCnt != '0) begin
                    deadCnt <= deadCnt - 1'b1;
                end else if (reversal) begin
                    // First low cycle of the dead time
                    deadCnt <= robotDrivePkg::DEAD_LOAD;
                    lastDir <= robotDrivePkg::off;
                end else if (cmdDir != robotDrivePkg::off) begin
                    lastDir <= cmdDir;
                end
            end
        end

        assign motorPins[m] = pinsQ;

    end

endmodule

`default_nettype wire

// ==== pwmChannel.sv ====
// PWM generator of one motor, duty chosen by a two-bit select and applied at period boundaries
`timescale 1ns/10ps
`default_nettype none

module pwmChannel (
    input  wire        clk,
    input  wire        arstN,
    input  wire  [1:0] dutySel,
    output logic       pwmOn
);

    logic [robotDrivePkg::PWM_CNT_W-1:0] periodCnt;
    logic [robotDrivePkg::DUTY_W-1:0]    dutyVal;
    logic [robotDrivePkg::DUTY_W-1:0]    dutyNext;

    // High cycles per period for the requested level
    assign dutyNext = {{(robotDrivePkg::DUTY_W - 2){1'b0}}, dutySel} * robotDrivePkg::DUTY_STEP;

    // ============================================================
    // Free-running period counter and duty latch
    // ============================================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            periodCnt <= '0;
            dutyVal   <= '0;
        end else begin
            if (periodCnt == robotDrivePkg::PWM_LAST) begin
                periodCnt <= '0;
                // New duty only from the next period so no pulse gets cut short
                dutyVal   <= dutyNext;
            end else begin
                periodCnt <= periodCnt + 1'b1;
            end
        end
    end

    // Registered compare output
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pwmOn <= 1'b0;
        end else begin
            pwmOn <= ({1'b0, periodCnt} < dutyVal);
        end
    end

endmodule

`default_nettype wire

// ==== goalDirectionControl.sv ====
// Search FSM of the robot, turns in place until a beacon, boundary wire or pause changes course
`timescale 1ns/10ps
`default_nettype none

module goalDirectionControl (
    input  wire                       clk,
    input  wire                       arstN,
    input  wire robotDrivePkg::sensorBusT sensors,
    output robotDrivePkg::motorCmdT [robotDrivePkg::NUM_MOTORS-1:0] motorCmd,
    output logic                      done
);

    robotDrivePkg::driveStateT state;
    robotDrivePkg::driveStateT nextState;
    // State to go back to after a pause or a back-up
    robotDrivePkg::driveStateT retState;
    logic [robotDrivePkg::DUR_CNT_W-1:0] durCnt;
    logic corrEnd;
    logic backUpMin;
    robotDrivePkg::motorCmdT [robotDrivePkg::NUM_MOTORS-1:0] nextCmd;

    // Shared duration counter, cleared on every state change
    assign corrEnd   = (durCnt == robotDrivePkg::CORRECT_LAST);
    assign backUpMin = (durCnt == robotDrivePkg::BACKUP_LAST);

    // ============================================================
    // Next state
    // ============================================================
    always_comb begin
        nextState = state;
        case (state)
            robotDrivePkg::idle: begin
                if (sensors.start) begin
                    nextState = robotDrivePkg::turnRight;
                end
            end
            robotDrivePkg::turnRight: begin
                // Pause wins over the boundary wire, which wins over both beacons
                if (sensors.pause) begin
                    nextState = robotDrivePkg::paused;
                end else if (sensors.inductance) begin
                    nextState = robotDrivePkg::backUp;
                end else if (sensors.ir1k) begin
                    nextState = robotDrivePkg::smallRight;
                end else if (sensors.ir10k) begin
                    nextState = robotDrivePkg::smallLeft;
                end
            end
            robotDrivePkg::smallRight, robotDrivePkg::smallLeft: begin
                if (corrEnd) begin
                    nextState = robotDrivePkg::idle;
                end
            end
            robotDrivePkg::paused: begin
                if (!sensors.pause) begin
                    nextState = retState;
                end
            end
            robotDrivePkg::backUp: begin
                // Minimum back-up time, extended while still over the wire
                if (backUpMin && !sensors.inductance) begin
                    nextState = retState;
                end
            end
            default: begin
                nextState = robotDrivePkg::idle;
            end
        endcase
    end

    // ============================================================
    // Motor commands for the state being entered
    // ============================================================
    always_comb begin
        nextCmd = {robotDrivePkg::NUM_MOTORS{robotDrivePkg::CMD_OFF}};
        case (nextState)
            robotDrivePkg::turnRight: begin
                nextCmd[robotDrivePkg::MOTOR_A] = '{dir: robotDrivePkg::forward, dutySel: 2'd1};
                nextCmd[robotDrivePkg::MOTOR_B] = '{dir: robotDrivePkg::backward, dutySel: 2'd1};
            end
            robotDrivePkg::smallRight: begin
                nextCmd[robotDrivePkg::MOTOR_A] = '{dir: robotDrivePkg::forward, dutySel: 2'd2};
                nextCmd[robotDrivePkg::MOTOR_B] = '{dir: robotDrivePkg::backward, dutySel: 2'd2};
            end
            robotDrivePkg::smallLeft: begin
                nextCmd[robotDrivePkg::MOTOR_A] = '{dir: robotDrivePkg::backward, dutySel: 2'd1};
                nextCmd[robotDrivePkg::MOTOR_B] = '{dir: robotDrivePkg::forward, dutySel: 2'd1};
            end
            robotDrivePkg::backUp: begin
                nextCmd[robotDrivePkg::MOTOR_A] = '{dir: robotDrivePkg::backward, dutySel: 2'd3};
                nextCmd[robotDrivePkg::MOTOR_B] = '{dir: robotDrivePkg::backward, dutySel: 2'd3};
            end
            default: begin
                // Idle and paused keep both motors off
            end
        endcase
    end

    // ============================================================
    // State, counter and done registers
    // ============================================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= robotDrivePkg::idle;
            retState <= robotDrivePkg::idle;
            durCnt   <= '0;
            done     <= 1'b0;
            motorCmd <= {robotDrivePkg::NUM_MOTORS{robotDrivePkg::CMD_OFF}};
        end else begin
            state    <= nextState;
            motorCmd <= nextCmd;

            if (nextState != state) begin
                durCnt <= '0;
            end else if (durCnt != robotDrivePkg::BACKUP_LAST) begin
                durCnt <= durCnt + 1'b1;
            end

            if (nextState != state &&
                (nextState == robotDrivePkg::paused || nextState == robotDrivePkg::backUp)) begin
                retState <= state;
            end

            // done marks a finished correction and clears when a new search starts
            if ((state == robotDrivePkg::smallRight || state == robotDrivePkg::smallLeft) &&
                nextState == robotDrivePkg::idle) begin
                done <= 1'b1;
            end else if (state == robotDrivePkg::idle && nextState != robotDrivePkg::idle) begin
                done <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== sensorConditioner.sv ====
// Input conditioning of the drive controller, synchronizes and deglitches raw levels and makes start
`timescale 1ns/10ps
`default_nettype none

module sensorConditioner (
    input  wire                       clk,
    input  wire                       arstN,
    input  wire                       enable,
    input  wire                       pause,
    input  wire                       inductance,
    input  wire                       ir1k,
    input  wire                       ir10k,
    output robotDrivePkg::sensorBusT  sensors
);

    // Raw levels in the same bit order as the sensor bus, enable sits in the start slot
    logic [robotDrivePkg::NUM_SENSORS-1:0] rawIn;
    logic [robotDrivePkg::NUM_SENSORS-1:0] syncA;
    logic [robotDrivePkg::NUM_SENSORS-1:0] syncB;
    logic [robotDrivePkg::NUM_SENSORS-1:0] filtered;
    logic [robotDrivePkg::FILTER_CNT_W-1:0] stableCnt [robotDrivePkg::NUM_SENSORS];
    robotDrivePkg::sensorBusT filtBus;
    logic enableDly;

    assign rawIn = {enable, pause, inductance, ir1k, ir10k};

    // ============================================================
    // Two-flop synchronizers
    // ============================================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            syncA <= '0;
            syncB <= '0;
        end else begin
            syncA <= rawIn;
            syncB <= syncA;
        end
    end

    // ============================================================
    // Glitch filter
    // ============================================================
    // A new level is taken only after it has held for FILTER_CYCLES clocks
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            filtered  <= '0;
            enableDly <= 1'b0;
            for (int i = 0; i < robotDrivePkg::NUM_SENSORS; i++) begin
                stableCnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < robotDrivePkg::NUM_SENSORS; i++) begin
                if (syncB[i] != filtered[i]) begin
                    if (stableCnt[i] == robotDrivePkg::FILTER_LAST) begin
                        filtered[i]  <= syncB[i];
                        stableCnt[i] <= '0;
                    end else begin
                        stableCnt[i] <= stableCnt[i] + 1'b1;
                    end
                end else begin
                    // Input bounced back, restart the stability count
                    stableCnt[i] <= '0;
                end
            end
            enableDly <= filtBus.start;
        end
    end

    assign filtBus = filtered;

    // Rising edge of the filtered enable becomes the start strobe
    always_comb begin
        sensors       = filtBus;
        sensors.start = filtBus.start & ~enableDly;
    end

endmodule

`default_nettype wire

// ==== robotDrivePkg.sv ====
// Shared types and constants of the robot drive RTL, referenced by scoped name from every module
`default_nettype none

package robotDrivePkg;

    // ============================================================
    // Motor count and PWM timing
    // ============================================================

    // Motor count and the index of each motor in the command and pin arrays
    localparam int NUM_MOTORS = 2;
    localparam int MOTOR_A    = 0;
    localparam int MOTOR_B    = 1;

    localparam int PWM_PERIOD = 16;
    localparam int PWM_CNT_W  = $clog2(PWM_PERIOD);
    localparam logic [PWM_CNT_W-1:0] PWM_LAST = PWM_CNT_W'(PWM_PERIOD - 1);

    // Duty value needs one extra bit so a full period fits
    localparam int DUTY_W = PWM_CNT_W + 1;
    localparam logic [DUTY_W-1:0] DUTY_STEP = DUTY_W'(4);

    // ============================================================
    // Input filter, controller durations and bridge dead time
    // ============================================================

    localparam int FILTER_CYCLES = 4;
    localparam int FILTER_CNT_W  = $clog2(FILTER_CYCLES);
    localparam logic [FILTER_CNT_W-1:0] FILTER_LAST = FILTER_CNT_W'(FILTER_CYCLES - 1);

    localparam int CORRECT_CYCLES = 64;
    localparam int BACKUP_CYCLES  = 128;
    localparam int DUR_CNT_W      =
        $clog2((BACKUP_CYCLES > CORRECT_CYCLES) ? BACKUP_CYCLES : CORRECT_CYCLES);
    localparam logic [DUR_CNT_W-1:0] CORRECT_LAST = DUR_CNT_W'(CORRECT_CYCLES - 1);
    localparam logic [DUR_CNT_W-1:0] BACKUP_LAST  = DUR_CNT_W'(BACKUP_CYCLES - 1);

    localparam int DEAD_CYCLES = 2;
    localparam int DEAD_CNT_W  = $clog2(DEAD_CYCLES + 1);
    localparam logic [DEAD_CNT_W-1:0] DEAD_LOAD = DEAD_CNT_W'(DEAD_CYCLES - 1);

    // ============================================================
    // Types
    // ============================================================

    typedef enum logic [2:0] {
        idle       = 3'd0,
        turnRight  = 3'd1,
        smallRight = 3'd2,
        smallLeft  = 3'd3,
        paused     = 3'd4,
        backUp     = 3'd5
    } driveStateT;

    typedef enum logic [1:0] {
        off      = 2'd0,
        forward  = 2'd1,
        backward = 2'd2
    } motorDirT;

    typedef struct packed {
        motorDirT   dir;
        logic [1:0] dutySel;
    } motorCmdT;

    localparam motorCmdT CMD_OFF = '{dir: off, dutySel: 2'd0};

    // Conditioned inputs, start is a one-cycle strobe and the rest are levels
    typedef struct packed {
        logic start;
        logic pause;
        logic inductance;
        logic ir1k;
        logic ir10k;
    } sensorBusT;

    localparam int NUM_SENSORS = $bits(sensorBusT);

    typedef struct packed {
        logic inA;
        logic inB;
    } bridgePinsT;

endpackage

`default_nettype wire
